//--- Makefile
# Verilator flow for the memory-sequence game

TOP = tb_circuito_jogo

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "Failure reported in sim.log"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" sim.log || \
		(echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- hdl/circuito_jogo.sv
// ***************************************************************************
// Memory-sequence game top level
// Joins the datapath, per-play timer and control unit, and decodes
// the counter, ROM word and state onto three debug displays
// ***************************************************************************

`timescale 1ns/1ps

module circuito_jogo (
    input  logic       clock,
    input  logic       reset,
    input  logic       iniciar,
    input  logic [3:0] chaves,
    input  logic       nivel_jogadas,
    input  logic       nivel_tempo,
    output logic       acertou,
    output logic       errou,
    output logic       pronto,
    output logic       timeout,
    output logic [3:0] leds,
    output logic       db_igual,
    output logic [6:0] db_contagem,
    output logic [6:0] db_memoria,
    output logic [6:0] db_estado,
    output logic       db_nivel_jogadas,
    output logic       db_nivel_tempo,
    output logic       db_tem_jogada,
    output logic       db_meio_tempo,
    output logic       db_fim_tempo
);

    // Control strobes
    logic zera_c;
    logic conta_c;
    logic zera_r;
    logic registra_r;
    logic registra_n;
    logic zera_t;
    logic conta_t;

    // Status back to the FSM
    logic igual;
    logic jogada_feita;
    logic fim_c;
    logic nivel_tempo_reg;
    logic meio_tempo;
    logic fim_tempo;

    // Raw debug nibbles before decoding
    logic [3:0] jogada;
    logic [3:0] hex_contagem;
    logic [3:0] hex_memoria;
    logic [3:0] hex_estado;

    jogo_fluxo_dados fluxo_dados (
        .clock            (clock),
        .reset            (reset),
        .chaves           (chaves),
        .nivel_jogadas    (nivel_jogadas),
        .nivel_tempo      (nivel_tempo),
        .zera_c           (zera_c),
        .conta_c          (conta_c),
        .zera_r           (zera_r),
        .registra_r       (registra_r),
        .registra_n       (registra_n),
        .igual            (igual),
        .jogada_feita     (jogada_feita),
        .fim_c            (fim_c),
        .nivel_tempo_reg  (nivel_tempo_reg),
        .jogada           (jogada),
        .db_contagem      (hex_contagem),
        .db_memoria       (hex_memoria),
        .db_tem_jogada    (db_tem_jogada),
        .db_nivel_jogadas (db_nivel_jogadas)
    );

    jogo_temporizador temporizador (
        .clock           (clock),
        .reset           (reset),
        .zera_t          (zera_t),
        .conta_t         (conta_t),
        .nivel_tempo_reg (nivel_tempo_reg),
        .meio_tempo      (meio_tempo),
        .fim_tempo       (fim_tempo)
    );

    jogo_unidade_controle unidade_controle (
        .clock        (clock),
        .reset        (reset),
        .iniciar      (iniciar),
        .fim_c        (fim_c),
        .jogada_feita (jogada_feita),
        .igual        (igual),
        .fim_tempo    (fim_tempo),
        .zera_c       (zera_c),
        .conta_c      (conta_c),
        .zera_r       (zera_r),
        .registra_r   (registra_r),
        .registra_n   (registra_n),
        .zera_t       (zera_t),
        .conta_t      (conta_t),
        .acertou      (acertou),
        .errou        (errou),
        .timeout      (timeout),
        .pronto       (pronto),
        .db_estado    (hex_estado)
    );

    // Displays for counter, ROM word and state
    hexa7seg hex0 (
        .hexa    (hex_contagem),
        .display (db_contagem)
    );

    hexa7seg hex1 (
        .hexa    (hex_memoria),
        .display (db_memoria)
    );

    hexa7seg hex3 (
        .hexa    (hex_estado),
        .display (db_estado)
    );

    // LEDs show the registered play
    assign leds           = jogada;
    assign db_igual       = igual;
    assign db_nivel_tempo = nivel_tempo_reg;
    assign db_meio_tempo  = meio_tempo;
    assign db_fim_tempo   = fim_tempo;

endmodule

//--- hdl/hexa7seg.sv
// ***************************************************************************
// Hex to seven-segment decoder
// Active-low segments, bit order gfedcba
// ***************************************************************************

`timescale 1ns/1ps

module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    always_comb begin
        case (hexa)
            4'h0:    display = 7'b1000000;
            4'h1:    display = 7'b1111001;
            4'h2:    display = 7'b0100100;
            4'h3:    display = 7'b0110000;
            4'h4:    display = 7'b0011001;
            4'h5:    display = 7'b0010010;
            4'h6:    display = 7'b0000010;
            4'h7:    display = 7'b1111000;
            4'h8:    display = 7'b0000000;
            4'h9:    display = 7'b0010000;
            4'hA:    display = 7'b0001000;
            // Lower-case b and d
            4'hB:    display = 7'b0000011;
            4'hC:    display = 7'b1000110;
            4'hD:    display = 7'b0100001;
            4'hE:    display = 7'b0000110;
            default: display = 7'b0001110;
        endcase
    end

endmodule

//--- hdl/jogo_fluxo_dados.sv
// ***************************************************************************
// Game datapath
// Round counter addressing the sequence ROM, play register and
// comparator, press edge detector and the two level registers
// ***************************************************************************

`timescale 1ns/1ps

module jogo_fluxo_dados (
    input  logic       clock,
    input  logic       reset,
    input  logic [3:0] chaves,
    input  logic       nivel_jogadas,
    input  logic       nivel_tempo,
    input  logic       zera_c,
    input  logic       conta_c,
    input  logic       zera_r,
    input  logic       registra_r,
    input  logic       registra_n,
    output logic       igual,
    output logic       jogada_feita,
    output logic       fim_c,
    output logic       nivel_tempo_reg,
    output logic [3:0] jogada,
    output logic [3:0] db_contagem,
    output logic [3:0] db_memoria,
    output logic       db_tem_jogada,
    output logic       db_nivel_jogadas
);

    typedef logic [jogo_pkg::LARG_ENDERECO-1:0] endereco_t;

    endereco_t  contagem;
    endereco_t  ultimo;
    logic [3:0] memoria;
    logic [3:0] chaves_anterior;
    logic       nivel_jogadas_reg;

    // Round counter, clear has priority
    always_ff @(posedge clock) begin
        if (reset) begin
            contagem <= '0;
        end else if (zera_c) begin
            contagem <= '0;
        end else if (conta_c) begin
            contagem <= contagem + 1'b1;
        end
    end

    // Sequence ROM
    assign memoria = jogo_pkg::SEQUENCIA[contagem];

    // Last address depends on game length
    assign ultimo = nivel_jogadas_reg ? endereco_t'(jogo_pkg::N_JOGADAS_MAX - 1)
                                      : endereco_t'(jogo_pkg::N_JOGADAS_MIN - 1);
    assign fim_c  = (contagem == ultimo);

    // Level registers, loaded once per game
    always_ff @(posedge clock) begin
        if (reset) begin
            nivel_jogadas_reg <= 1'b0;
            nivel_tempo_reg   <= 1'b0;
        end else if (registra_n) begin
            nivel_jogadas_reg <= nivel_jogadas;
            nivel_tempo_reg   <= nivel_tempo;
        end
    end

    // Previous sample of the switches
    always_ff @(posedge clock) begin
        if (reset) begin
            chaves_anterior <= '0;
        end else begin
            chaves_anterior <= chaves;
        end
    end

    // Press edge: released last cycle, something pressed now
    assign jogada_feita = (chaves != 4'b0000) && (chaves_anterior == 4'b0000);

    // Play register
    always_ff @(posedge clock) begin
        if (reset) begin
            jogada <= '0;
        end else if (zera_r) begin
            jogada <= '0;
        end else if (registra_r) begin
            jogada <= chaves;
        end
    end

    assign igual = (jogada == memoria);

    // Debug
    assign db_contagem      = contagem;
    assign db_memoria       = memoria;
    assign db_tem_jogada    = jogada_feita;
    assign db_nivel_jogadas = nivel_jogadas_reg;

endmodule

//--- hdl/jogo_pkg.sv
// ***************************************************************************
// Memory-sequence game shared definitions
// Control FSM state encoding, sequence ROM contents and the size and
// timing constants used by the datapath, timer and testbench
// ***************************************************************************

package jogo_pkg;

    // Round counter and sequence length
    localparam int LARG_ENDERECO = 4;
    localparam int N_JOGADAS_MAX = 16;
    localparam int N_JOGADAS_MIN = 8;

    // Per-play time limits in clock cycles, kept short for simulation
    localparam int LARG_TEMPO  = 8;
    localparam int TEMPO_LONGO = 200;
    localparam int TEMPO_CURTO = 100;

    // FSM states, 4 bits so the code goes straight to a display digit
    typedef enum logic [3:0] {
        INICIAL       = 4'h0,
        PREPARACAO    = 4'h1,
        ESPERA_JOGADA = 4'h2,
        REGISTRA      = 4'h4,
        COMPARACAO    = 4'h5,
        PROXIMA       = 4'h6,
        FIM_ACERTOU   = 4'hA,
        FIM_ERROU     = 4'hE,
        FIM_TIMEOUT   = 4'hF
    } estado_t;

    // Fixed sequence of one-hot plays
    // Level 0 uses the first 8 words only
    localparam logic [3:0] SEQUENCIA [0:N_JOGADAS_MAX-1] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b0010, 4'b0010, 4'b0100, 4'b0100,
        4'b1000, 4'b1000, 4'b0001, 4'b0100
    };

endpackage

//--- hdl/jogo_temporizador.sv
// ***************************************************************************
// Per-play timer
// Counts cycles while enabled up to a long or short limit and flags
// the half-way point and the end of the allowed time
// ***************************************************************************

`timescale 1ns/1ps

module jogo_temporizador (
    input  logic clock,
    input  logic reset,
    input  logic zera_t,
    input  logic conta_t,
    input  logic nivel_tempo_reg,
    output logic meio_tempo,
    output logic fim_tempo
);

    typedef logic [jogo_pkg::LARG_TEMPO-1:0] tempo_t;

    tempo_t contagem;
    tempo_t limite;

    // Short limit on time level 1
    assign limite = nivel_tempo_reg ? tempo_t'(jogo_pkg::TEMPO_CURTO)
                                    : tempo_t'(jogo_pkg::TEMPO_LONGO);

    // Cycle counter, saturates at the limit
    always_ff @(posedge clock) begin
        if (reset) begin
            contagem <= '0;
        end else if (zera_t) begin
            contagem <= '0;
        end else if (conta_t && (contagem < limite)) begin
            contagem <= contagem + 1'b1;
        end
    end

    // Half flag stays up from mid-limit onward
    assign meio_tempo = (contagem >= (limite >> 1));
    assign fim_tempo  = (contagem == limite);

endmodule

//--- hdl/jogo_unidade_controle.sv
// ***************************************************************************
// Game control unit
// Moore FSM that prepares a round, waits for each press, registers and
// compares it, and ends the game in hit, miss or timeout
// ***************************************************************************

`timescale 1ns/1ps

module jogo_unidade_controle (
    input  logic       clock,
    input  logic       reset,
    input  logic       iniciar,
    input  logic       fim_c,
    input  logic       jogada_feita,
    input  logic       igual,
    input  logic       fim_tempo,
    output logic       zera_c,
    output logic       conta_c,
    output logic       zera_r,
    output logic       registra_r,
    output logic       registra_n,
    output logic       zera_t,
    output logic       conta_t,
    output logic       acertou,
    output logic       errou,
    output logic       timeout,
    output logic       pronto,
    output logic [3:0] db_estado
);

    jogo_pkg::estado_t estado;
    jogo_pkg::estado_t proximo;

    // State register
    always_ff @(posedge clock) begin
        if (reset) begin
            estado <= jogo_pkg::INICIAL;
        end else begin
            estado <= proximo;
        end
    end

    // Next-state logic
    always_comb begin
        proximo = estado;
        case (estado)
            jogo_pkg::INICIAL: begin
                if (iniciar) begin
                    proximo = jogo_pkg::PREPARACAO;
                end
            end
            // Single cycle, clears everything and latches levels
            jogo_pkg::PREPARACAO: begin
                proximo = jogo_pkg::ESPERA_JOGADA;
            end
            // Press wins over a timeout in the same cycle
            jogo_pkg::ESPERA_JOGADA: begin
                if (jogada_feita) begin
                    proximo = jogo_pkg::REGISTRA;
                end else if (fim_tempo) begin
                    proximo = jogo_pkg::FIM_TIMEOUT;
                end
            end
            jogo_pkg::REGISTRA: begin
                proximo = jogo_pkg::COMPARACAO;
            end
            jogo_pkg::COMPARACAO: begin
                if (!igual) begin
                    proximo = jogo_pkg::FIM_ERROU;
                end else if (fim_c) begin
                    proximo = jogo_pkg::FIM_ACERTOU;
                end else begin
                    proximo = jogo_pkg::PROXIMA;
                end
            end
            jogo_pkg::PROXIMA: begin
                proximo = jogo_pkg::ESPERA_JOGADA;
            end
            // Final states hold until a new start
            jogo_pkg::FIM_ACERTOU,
            jogo_pkg::FIM_ERROU,
            jogo_pkg::FIM_TIMEOUT: begin
                if (iniciar) begin
                    proximo = jogo_pkg::PREPARACAO;
                end
            end
            default: begin
                proximo = jogo_pkg::INICIAL;
            end
        endcase
    end

    // Datapath and timer strobes, from current state only
    assign zera_c     = (estado == jogo_pkg::PREPARACAO);
    assign zera_r     = (estado == jogo_pkg::PREPARACAO);
    assign registra_n = (estado == jogo_pkg::PREPARACAO);
    assign registra_r = (estado == jogo_pkg::REGISTRA);
    assign conta_c    = (estado == jogo_pkg::PROXIMA);
    assign conta_t    = (estado == jogo_pkg::ESPERA_JOGADA);

    // Timer restarts for the first play and for every new round
    assign zera_t = (estado == jogo_pkg::PREPARACAO) || (estado == jogo_pkg::PROXIMA);

    // Result flags
    assign acertou = (estado == jogo_pkg::FIM_ACERTOU);
    assign errou   = (estado == jogo_pkg::FIM_ERROU);
    assign timeout = (estado == jogo_pkg::FIM_TIMEOUT);
    assign pronto  = acertou || errou || timeout;

    // State code for the debug display
    assign db_estado = estado;

endmodule

//--- tests/jogo_stim.txt
// Game scenarios, one per line, every field in hex
// nivel_jogadas nivel_tempo corretas errada(0 none) segura ocioso fim(A hit, E miss, F timeout)
// segura holds the last correct key down, ocioso is idle cycles before the first press
0 0 08 0 0 02 A
1 0 10 0 0 01 A
1 0 08 0 0 00 F
0 1 00 0 0 00 F
0 0 00 0 0 03 F
0 0 00 8 0 00 E
0 0 03 2 0 01 E
1 1 0B 1 0 03 E
0 0 07 4 0 00 E
0 0 07 0 1 00 F
1 1 09 0 1 02 F
1 1 10 0 0 00 A
0 1 05 0 0 05 F
0 0 02 F 0 01 E
0 1 08 0 0 00 A

//--- tests/tb_circuito_jogo.sv
// ***************************************************************************
// Testbench for the memory-sequence game
// Reads game scenarios from the stim file and plays them on the top
// level, checking endings, counter, LEDs, levels and timer flags
// ***************************************************************************

`timescale 1ns/1ps

module tb_circuito_jogo;

    localparam int CAMPOS       = 7;
    localparam int MAX_CENARIOS = 32;
    localparam int MARGEM       = 4;

    logic       clock;
    logic       reset;
    logic       iniciar;
    logic [3:0] chaves;
    logic       nivel_jogadas;
    logic       nivel_tempo;
    logic       acertou;
    logic       errou;
    logic       pronto;
    logic       timeout;
    logic [3:0] leds;
    logic       db_igual;
    logic [6:0] db_contagem;
    logic [6:0] db_memoria;
    logic [6:0] db_estado;
    logic       db_nivel_jogadas;
    logic       db_nivel_tempo;
    logic       db_tem_jogada;
    logic       db_meio_tempo;
    logic       db_fim_tempo;

    // Seven fields per scenario
    // Unused entries keep the FF fill
    logic [7:0] stim [0:CAMPOS*MAX_CENARIOS-1];
    int         cenarios;
    int         ciclos = 0;
    int         limite_ciclos = 0;
    int         medido_curto = -1;
    int         medido_longo = -1;
    integer     semente;

    circuito_jogo i_circuito_jogo (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Watchdog
    always @(posedge clock) begin
        ciclos <= ciclos + 1;
        if (limite_ciclos > 0 && ciclos > limite_ciclos) begin
            encerra_com_falha($sformatf("Run did not finish within %0d cycles", limite_ciclos));
        end
    end

    task automatic encerra_com_falha(input string motivo);
        $display("%s", motivo);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Active-low gfedcba with lower-case b and d
    function automatic logic [6:0] segmentos(input logic [3:0] digito);
        case (digito)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b0000011;
            4'hC:    return 7'b1000110;
            4'hD:    return 7'b0100001;
            4'hE:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    task automatic compara_bit(input string nome, input logic valor, input logic esperado);
        if (valor !== esperado) begin
            encerra_com_falha($sformatf("ERROR at time %0t: %s = %b, expected %b",
                                        $time, nome, valor, esperado));
        end
    endtask

    task automatic compara_estado(input jogo_pkg::estado_t esperado);
        if (db_estado !== segmentos(esperado)) begin
            encerra_com_falha($sformatf("ERROR at time %0t: db_estado = %b, expected %b (%s)",
                                        $time, db_estado, segmentos(esperado), esperado.name()));
        end
    endtask

    task automatic compara_contagem(input int esperado);
        if (db_contagem !== segmentos(4'(esperado))) begin
            encerra_com_falha($sformatf("ERROR at time %0t: db_contagem = %b, expected %b (%0d)",
                                        $time, db_contagem, segmentos(4'(esperado)), esperado));
        end
    endtask

    task automatic compara_memoria(input logic [3:0] esperado);
        if (db_memoria !== segmentos(esperado)) begin
            encerra_com_falha($sformatf("ERROR at time %0t: db_memoria = %b, expected %b (%h)",
                                        $time, db_memoria, segmentos(esperado), esperado));
        end
    endtask

    task automatic compara_jogada(input logic [3:0] esperado);
        if (leds !== esperado) begin
            encerra_com_falha($sformatf("ERROR at time %0t: leds = %b, expected %b",
                                        $time, leds, esperado));
        end
    endtask

    // Start pulse and one preparation cycle before the first wait
    task automatic inicia_jogo(input logic nj, input logic nt);
        nivel_jogadas = nj;
        nivel_tempo   = nt;
        iniciar       = 1'b1;
        @(negedge clock);
        iniciar = 1'b0;
        compara_estado(jogo_pkg::PREPARACAO);
        @(negedge clock);
        compara_estado(jogo_pkg::ESPERA_JOGADA);
        compara_contagem(0);
        compara_jogada(4'b0000);
        compara_bit("db_nivel_jogadas", db_nivel_jogadas, nj);
        compara_bit("db_nivel_tempo", db_nivel_tempo, nt);
        // Timer just restarted
        compara_bit("db_meio_tempo", db_meio_tempo, 1'b0);
        compara_bit("db_fim_tempo", db_fim_tempo, 1'b0);
        // Levels are latched, so flipping the inputs now must not matter
        nivel_jogadas = ~nj;
        nivel_tempo   = ~nt;
    endtask

    // Register after 2 edges and decision after 3
    task automatic pressiona(input logic [3:0] tecla, input jogo_pkg::estado_t decisao,
                             input bit segura);
        int folga;
        chaves = tecla;
        // Press pulse seen by the first edge only
        @(posedge clock);
        compara_bit("db_tem_jogada", db_tem_jogada, 1'b1);
        @(negedge clock);
        compara_bit("db_tem_jogada", db_tem_jogada, 1'b0);
        @(negedge clock);
        compara_jogada(tecla);
        compara_bit("db_igual", db_igual, decisao != jogo_pkg::FIM_ERROU);
        @(negedge clock);
        compara_estado(decisao);
        if (!segura) begin
            @(negedge clock);
            chaves = 4'b0000;
            folga  = 1 + ($unsigned($random(semente)) % 5);
            repeat (folga) @(negedge clock);
        end
    endtask

    task automatic executa_cenario(input int c);
        logic              nj;
        logic              nt;
        int                corretas;
        logic [3:0]        errada;
        bit                segura;
        int                ocioso;
        jogo_pkg::estado_t fim;
        jogo_pkg::estado_t decisao;
        int                n_total;
        int                inicio;
        int                duracao;
        int                limite;
        bit                meio_visto;
        nj       = stim[CAMPOS*c][0];
        nt       = stim[CAMPOS*c+1][0];
        corretas = int'(stim[CAMPOS*c+2]);
        errada   = stim[CAMPOS*c+3][3:0];
        segura   = stim[CAMPOS*c+4][0];
        ocioso   = int'(stim[CAMPOS*c+5]);
        fim      = jogo_pkg::estado_t'(stim[CAMPOS*c+6][3:0]);
        n_total  = nj ? jogo_pkg::N_JOGADAS_MAX : jogo_pkg::N_JOGADAS_MIN;

        inicia_jogo(nj, nt);
        inicio = ciclos;
        repeat (ocioso) @(negedge clock);
        for (int k = 0; k < corretas; k++) begin
            decisao = (k == n_total - 1) ? jogo_pkg::FIM_ACERTOU : jogo_pkg::PROXIMA;
            compara_memoria(jogo_pkg::SEQUENCIA[k]);
            pressiona(jogo_pkg::SEQUENCIA[k], decisao, segura && (k == corretas - 1));
        end

        // Key still down so the next round keeps waiting
        if (segura) begin
            repeat (8) begin
                @(negedge clock);
                compara_estado(jogo_pkg::ESPERA_JOGADA);
                compara_contagem(corretas);
            end
        end

        if (errada != 4'b0000) begin
            if (errada == jogo_pkg::SEQUENCIA[corretas]) begin
                encerra_com_falha($sformatf("Scenario %0d has a wrong play that matches", c));
            end
            compara_memoria(jogo_pkg::SEQUENCIA[corretas]);
            pressiona(errada, jogo_pkg::FIM_ERROU, 1'b0);
        end

        meio_visto = 1'b0;
        while (!pronto) begin
            if (db_meio_tempo) begin
                meio_visto = 1'b1;
            end
            @(negedge clock);
        end
        duracao = ciclos - inicio;
        chaves  = 4'b0000;

        compara_bit("pronto", pronto, 1'b1);
        compara_bit("acertou", acertou, fim == jogo_pkg::FIM_ACERTOU);
        compara_bit("errou", errou, fim == jogo_pkg::FIM_ERROU);
        compara_bit("timeout", timeout, fim == jogo_pkg::FIM_TIMEOUT);
        compara_estado(fim);
        compara_contagem((fim == jogo_pkg::FIM_ACERTOU) ? n_total - 1 : corretas);
        if (fim == jogo_pkg::FIM_TIMEOUT) begin
            compara_bit("db_fim_tempo", db_fim_tempo, 1'b1);
        end

        // No press at all, so the wait is exactly one timer run
        if (corretas == 0 && errada == 4'b0000) begin
            limite = nt ? jogo_pkg::TEMPO_CURTO : jogo_pkg::TEMPO_LONGO;
            if (!meio_visto) begin
                encerra_com_falha($sformatf("Scenario %0d timed out without half-time flag", c));
            end
            if (duracao < limite || duracao > limite + MARGEM) begin
                encerra_com_falha($sformatf("Scenario %0d timed out after %0d cycles, not %0d to %0d",
                                            c, duracao, limite, limite + MARGEM));
            end
            if (nt) begin
                medido_curto = duracao;
            end else begin
                medido_longo = duracao;
            end
        end

        // Presses in a final state are ignored
        chaves = jogo_pkg::SEQUENCIA[0];
        repeat (3) @(negedge clock);
        compara_estado(fim);
        chaves = 4'b0000;
        @(negedge clock);
    endtask

    initial begin
        reset         = 1'b1;
        iniciar       = 1'b0;
        chaves        = 4'b0000;
        nivel_jogadas = 1'b0;
        nivel_tempo   = 1'b0;
        semente       = 32'hcec93e5b;

        for (int i = 0; i < CAMPOS*MAX_CENARIOS; i++) begin
            stim[i] = 8'hFF;
        end
        $readmemh("tests/jogo_stim.txt", stim);
        cenarios = 0;
        while (cenarios < MAX_CENARIOS && stim[CAMPOS*cenarios] != 8'hFF) begin
            cenarios++;
        end
        limite_ciclos = cenarios * jogo_pkg::N_JOGADAS_MAX * (jogo_pkg::TEMPO_LONGO + 10);

        repeat (3) @(negedge clock);
        reset = 1'b0;
        compara_bit("pronto", pronto, 1'b0);
        compara_bit("acertou", acertou, 1'b0);
        compara_bit("errou", errou, 1'b0);
        compara_bit("timeout", timeout, 1'b0);
        compara_estado(jogo_pkg::INICIAL);

        for (int c = 0; c < cenarios; c++) begin
            executa_cenario(c);
        end

        if (medido_curto >= 0 && medido_longo >= 0 && medido_curto >= medido_longo) begin
            encerra_com_falha("Short time level did not time out before the long one");
        end

        if (cenarios == 0) begin
            $display("No scenario lines found in tests/jogo_stim.txt");
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- verilog.f
hdl/jogo_pkg.sv
hdl/hexa7seg.sv
hdl/jogo_fluxo_dados.sv
hdl/jogo_temporizador.sv
hdl/jogo_unidade_controle.sv
hdl/circuito_jogo.sv
tests/tb_circuito_jogo.sv
